// ==== hw/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN         32
`define RV_REG_AW       5
`define RV_IADDR_W      16
`define RV_RESET_ADDR   16'h0000

// Major opcodes of the supported RV32I subset.
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_JAL      7'b1101111

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } rv_r_type_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } rv_i_type_t;

    typedef struct packed {
        logic                   imm12;          // Sign bit of the branch offset.
        logic [5:0]             imm10_5;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } rv_b_type_t;

    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
        rv_b_type_t b;
    } rv_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } rv_alu_op_e;

endpackage

// ==== hw/rv_dec_exe_if.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

interface rv_dec_exe_if
    import rv_pkg::*;
();
    logic                       valid;
    logic [`RV_IADDR_W-1:0]     pc;
    logic [`RV_REG_AW-1:0]      rs1;
    logic [`RV_REG_AW-1:0]      rs2;
    logic [`RV_XLEN-1:0]        rs1_data;
    logic [`RV_XLEN-1:0]        rs2_data;
    logic [`RV_REG_AW-1:0]      rd;
    logic                       writes_rd;
    logic [`RV_XLEN-1:0]        imm;
    logic                       use_imm;   // Operand B is the immediate.
    rv_alu_op_e                 alu_op;
    logic                       is_branch;
    logic                       is_jal;
    logic [2:0]                 funct3;

    modport decode (
        output valid, pc, rs1, rs2, rs1_data, rs2_data, rd, writes_rd,
               imm, use_imm, alu_op, is_branch, is_jal, funct3
    );

    modport execute (
        input  valid, pc, rs1, rs2, rs1_data, rs2_data, rd, writes_rd,
               imm, use_imm, alu_op, is_branch, is_jal, funct3
    );

endinterface

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_redirect,
    input  logic [`RV_IADDR_W-1:0]      i_redirect_pc,
    input  logic                        i_instr_ack,
    input  logic [`RV_XLEN-1:0]         i_instr_data,
    output logic                        o_instr_req,
    output logic [`RV_IADDR_W-1:0]      o_instr_addr,
    output logic                        o_valid,
    output logic [`RV_IADDR_W-1:0]      o_pc,
    output rv_instr_u                   o_instr
);

    logic [`RV_IADDR_W-1:0] pc;

    // Nothing downstream stalls, so fetch always wants the next word.
    assign o_instr_req = 1'b1;
    assign o_instr_addr = pc;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc <= `RV_RESET_ADDR;
            o_valid <= 1'b0;
        end
        else if (i_redirect)
        begin
            pc <= i_redirect_pc;    // An ack in this cycle is for the wrong path.
            o_valid <= 1'b0;
        end
        else
        begin
            if (i_instr_ack)
                pc <= pc + 3'd4;
            o_valid <= i_instr_ack;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_instr_ack)
        begin
            o_pc <= pc;
            o_instr <= i_instr_data;
        end
    end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_flush,
    input  logic                        i_valid,
    input  logic [`RV_IADDR_W-1:0]      i_pc,
    input  rv_instr_u                   i_instr,
    output logic [`RV_REG_AW-1:0]       o_rs1,
    output logic [`RV_REG_AW-1:0]       o_rs2,
    input  logic [`RV_XLEN-1:0]         i_rs1_data,
    input  logic [`RV_XLEN-1:0]         i_rs2_data,
    rv_dec_exe_if.decode                dx
);

    logic [6:0]             opcode;
    logic                   alt;
    logic                   supported;
    logic                   writes_rd;
    logic                   use_imm;
    logic                   is_branch;
    logic                   is_jal;
    logic [`RV_XLEN-1:0]    imm;
    rv_alu_op_e             alu_op;

    // SUB exists only for register operands, SRA for both forms.
    function automatic rv_alu_op_e alu_from_funct3(input logic [2:0] funct3,
                                                   input logic alt_bit,
                                                   input logic reg_form);
        case (funct3)
            3'b000:  return (reg_form && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_instr.r.opcode;
    assign alt = i_instr.r.funct7[5];   // Same bit as imm12[10] for shift immediates.

    always_comb
    begin
        supported = 1'b1;
        writes_rd = 1'b0;
        use_imm = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        imm = '0;
        o_rs1 = '0;
        o_rs2 = '0;
        alu_op = ALU_ADD;
        case (opcode)
            `RV_OPC_OP:
            begin
                writes_rd = 1'b1;
                o_rs1 = i_instr.r.rs1;
                o_rs2 = i_instr.r.rs2;
                alu_op = alu_from_funct3(i_instr.r.funct3, alt, 1'b1);
            end
            `RV_OPC_OP_IMM:
            begin
                writes_rd = 1'b1;
                use_imm = 1'b1;
                o_rs1 = i_instr.i.rs1;
                imm = {{(`RV_XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
                alu_op = alu_from_funct3(i_instr.i.funct3, alt, 1'b0);
            end
            `RV_OPC_LUI:
            begin
                writes_rd = 1'b1;
                use_imm = 1'b1;
                imm = {i_instr[31:12], 12'b0};
                alu_op = ALU_PASS_B;
            end
            `RV_OPC_BRANCH:
            begin
                is_branch = 1'b1;
                o_rs1 = i_instr.b.rs1;
                o_rs2 = i_instr.b.rs2;
                imm = {{(`RV_XLEN-12){i_instr.b.imm12}}, i_instr.b.imm11,
                       i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
            end
            `RV_OPC_JAL:
            begin
                writes_rd = 1'b1;
                is_jal = 1'b1;
                imm = {{(`RV_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                       i_instr[30:21], 1'b0};
            end
            default:
                supported = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            dx.valid <= 1'b0;
        else
            dx.valid <= i_valid && supported && !i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        dx.pc <= i_pc;
        dx.rs1 <= o_rs1;
        dx.rs2 <= o_rs2;
        dx.rs1_data <= i_rs1_data;
        dx.rs2_data <= i_rs2_data;
        dx.rd <= i_instr.r.rd;
        dx.writes_rd <= writes_rd;
        dx.imm <= imm;
        dx.use_imm <= use_imm;
        dx.alu_op <= alu_op;
        dx.is_branch <= is_branch;
        dx.is_jal <= is_jal;
        dx.funct3 <= i_instr.r.funct3;
    end

endmodule

// ==== hw/rv_regs.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_regs
(
    input  logic                        i_clk,
    input  logic [`RV_REG_AW-1:0]       i_rs1,
    input  logic [`RV_REG_AW-1:0]       i_rs2,
    output logic [`RV_XLEN-1:0]         o_rs1_data,
    output logic [`RV_XLEN-1:0]         o_rs2_data,
    input  logic                        i_wr_en,
    input  logic [`RV_REG_AW-1:0]       i_wr_rd,
    input  logic [`RV_XLEN-1:0]         i_wr_data
);

    logic [`RV_XLEN-1:0] regs [1:(2**`RV_REG_AW)-1];   // x0 has no storage.

    always_ff @(posedge i_clk)
    begin
        if (i_wr_en && (i_wr_rd != '0))
            regs[i_wr_rd] <= i_wr_data;
    end

    // A write in the same cycle is passed straight through to the reader.
    assign o_rs1_data = (i_rs1 == '0) ? '0 :
                        (i_wr_en && (i_wr_rd == i_rs1)) ? i_wr_data : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 :
                        (i_wr_en && (i_wr_rd == i_rs2)) ? i_wr_data : regs[i_rs2];

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    rv_dec_exe_if.execute               dx,
    output logic                        o_redirect,
    output logic [`RV_IADDR_W-1:0]      o_redirect_pc,
    output logic                        o_retire_valid,
    output logic [`RV_REG_AW-1:0]       o_retire_rd,
    output logic [`RV_XLEN-1:0]         o_retire_data
);

    logic [`RV_XLEN-1:0]        op_a;
    logic [`RV_XLEN-1:0]        op_b_reg;
    logic [`RV_XLEN-1:0]        op_b;
    logic [`RV_XLEN-1:0]        alu_result;
    logic [`RV_XLEN-1:0]        result;
    logic [`RV_IADDR_W-1:0]     link_pc;
    logic                       branch_cond;
    logic                       write_en;

    // The retire register holds the instruction just ahead; x0 is never retired.
    assign op_a = (o_retire_valid && (o_retire_rd == dx.rs1)) ? o_retire_data : dx.rs1_data;
    assign op_b_reg = (o_retire_valid && (o_retire_rd == dx.rs2)) ? o_retire_data : dx.rs2_data;
    assign op_b = dx.use_imm ? dx.imm : op_b_reg;

    always_comb
    begin
        case (dx.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    always_comb
    begin
        case (dx.funct3)
            3'b000:  branch_cond = (op_a == op_b_reg);
            3'b001:  branch_cond = (op_a != op_b_reg);
            3'b100:  branch_cond = ($signed(op_a) < $signed(op_b_reg));
            3'b101:  branch_cond = ($signed(op_a) >= $signed(op_b_reg));
            3'b110:  branch_cond = (op_a < op_b_reg);
            3'b111:  branch_cond = (op_a >= op_b_reg);
            default: branch_cond = 1'b0;
        endcase
    end

    assign link_pc = dx.pc + 3'd4;
    assign result = dx.is_jal ? {{(`RV_XLEN-`RV_IADDR_W){1'b0}}, link_pc} : alu_result;

    assign o_redirect = dx.valid && (dx.is_jal || (dx.is_branch && branch_cond));
    assign o_redirect_pc = dx.pc + dx.imm[`RV_IADDR_W-1:0];

    assign write_en = dx.valid && dx.writes_rd && (dx.rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_retire_valid <= 1'b0;
        else
            o_retire_valid <= write_en;
    end

    always_ff @(posedge i_clk)
    begin
        if (write_en)
        begin
            o_retire_rd <= dx.rd;
            o_retire_data <= result;
        end
    end

endmodule

// ==== hw/rv_top.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_top
    import rv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    output logic                        o_instr_req,
    output logic [`RV_IADDR_W-1:0]      o_instr_addr,
    input  logic                        i_instr_ack,
    input  logic [`RV_XLEN-1:0]         i_instr_data,
    output logic                        o_retire_valid,
    output logic [`RV_REG_AW-1:0]       o_retire_rd,
    output logic [`RV_XLEN-1:0]         o_retire_data
);

    logic                       redirect;
    logic [`RV_IADDR_W-1:0]     redirect_pc;
    logic                       fetch_valid;
    logic [`RV_IADDR_W-1:0]     fetch_pc;
    rv_instr_u                  fetch_instr;
    logic [`RV_REG_AW-1:0]      rs1;
    logic [`RV_REG_AW-1:0]      rs2;
    logic [`RV_XLEN-1:0]        rs1_data;
    logic [`RV_XLEN-1:0]        rs2_data;

    rv_dec_exe_if dx ();

    rv_fetch u_fetch
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_redirect         (redirect),
        .i_redirect_pc      (redirect_pc),
        .i_instr_ack        (i_instr_ack),
        .i_instr_data       (i_instr_data),
        .o_instr_req        (o_instr_req),
        .o_instr_addr       (o_instr_addr),
        .o_valid            (fetch_valid),
        .o_pc               (fetch_pc),
        .o_instr            (fetch_instr)
    );

    rv_decode u_decode
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_flush            (redirect),
        .i_valid            (fetch_valid),
        .i_pc               (fetch_pc),
        .i_instr            (fetch_instr),
        .o_rs1              (rs1),
        .o_rs2              (rs2),
        .i_rs1_data         (rs1_data),
        .i_rs2_data         (rs2_data),
        .dx                 (dx.decode)
    );

    // The retire register is also the register file write port.
    rv_regs u_regs
    (
        .i_clk              (i_clk),
        .i_rs1              (rs1),
        .i_rs2              (rs2),
        .o_rs1_data         (rs1_data),
        .o_rs2_data         (rs2_data),
        .i_wr_en            (o_retire_valid),
        .i_wr_rd            (o_retire_rd),
        .i_wr_data          (o_retire_data)
    );

    rv_execute u_execute
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .dx                 (dx.execute),
        .o_redirect         (redirect),
        .o_redirect_pc      (redirect_pc),
        .o_retire_valid     (o_retire_valid),
        .o_retire_rd        (o_retire_rd),
        .o_retire_data      (o_retire_data)
    );

endmodule

// ==== tests/rv_assertions.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_assertions
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        o_instr_req,
    input  logic [`RV_IADDR_W-1:0]      o_instr_addr,
    input  logic                        o_retire_valid,
    input  logic [`RV_REG_AW-1:0]       o_retire_rd
);

    req_after_reset: assert property (@(posedge i_clk)
                                      i_reset |=> (o_instr_req &&
                                                   (o_instr_addr == `RV_RESET_ADDR)))
        else $error("instruction request is not at the reset address after reset");

    no_x0_retire: assert property (@(posedge i_clk) disable iff (i_reset)
                                   o_retire_valid |-> (o_retire_rd != '0))
        else $error("retire reported for register x0");

    quiet_in_reset: assert property (@(posedge i_clk) i_reset |=> !o_retire_valid)
        else $error("retire valid high during reset");

endmodule

bind rv_top rv_assertions u_assertions
(
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .o_instr_req    (o_instr_req),
    .o_instr_addr   (o_instr_addr),
    .o_retire_valid (o_retire_valid),
    .o_retire_rd    (o_retire_rd)
);

// ==== tests/rv_checker.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_checker
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_instr_req,
    input  logic [`RV_IADDR_W-1:0]      i_instr_addr,
    input  logic                        i_instr_ack,
    input  logic                        i_retire_valid,
    input  logic [`RV_REG_AW-1:0]       i_retire_rd,
    input  logic [`RV_XLEN-1:0]         i_retire_data,
    input  logic [31:0]                 i_mem [0:255],
    input  logic                        i_test_end,
    input  int                          i_test_num,
    output int                          o_pending,
    output int                          o_errors,
    output int                          o_tests_failed
);

    logic [31:0]    model_regs [0:31];
    logic [31:0]    model_pc;
    logic [4:0]     exp_rd [$];
    logic [31:0]    exp_data [$];
    logic [4:0]     nrd;
    logic [31:0]    ndata;
    logic           prev_reset = 1'b0;
    logic           seen_ack = 1'b0;
    int             errors = 0;
    int             tests_failed = 0;
    int             test_errors = 0;
    int             retires = 0;

    assign o_errors = errors;
    assign o_tests_failed = tests_failed;

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Steps the ISA model until it writes a nonzero register; returns 0 on halt.
    function automatic logic next_write(output logic [4:0] rd, output logic [31:0] data);
        logic [31:0]    instr;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    imm;
        logic [2:0]     f3;
        logic           wrote;
        rd = '0;
        data = '0;
        for (int n = 0; n < 256; n++)
        begin
            instr = i_mem[model_pc[9:2]];
            rd = instr[11:7];
            f3 = instr[14:12];
            a = (instr[19:15] == 5'd0) ? 32'd0 : model_regs[instr[19:15]];
            b = (instr[24:20] == 5'd0) ? 32'd0 : model_regs[instr[24:20]];
            wrote = 1'b1;
            case (instr[6:0])
                `RV_OPC_OP:
                begin
                    data = alu_ref(f3, instr[30], a, b);
                    model_pc = model_pc + 32'd4;
                end
                `RV_OPC_OP_IMM:
                begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                    data = alu_ref(f3, instr[30] && (f3 == 3'd5), a, imm);
                    model_pc = model_pc + 32'd4;
                end
                `RV_OPC_LUI:
                begin
                    data = {instr[31:12], 12'b0};
                    model_pc = model_pc + 32'd4;
                end
                `RV_OPC_BRANCH:
                begin
                    wrote = 1'b0;
                    imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                    model_pc = branch_taken(f3, a, b) ? model_pc + imm : model_pc + 32'd4;
                end
                `RV_OPC_JAL:
                begin
                    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                    if (imm == 32'd0)
                        return 1'b0;    // A jump to itself ends the program.
                    data = model_pc + 32'd4;
                    model_pc = model_pc + imm;
                end
                default:
                    return 1'b0;
            endcase
            if (wrote && (rd != 5'd0))
            begin
                model_regs[rd] = data;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic start_test();
        if (!i_instr_req)
        begin
            $display("ERROR at %0t: no instruction request after reset", $time);
            errors++;
            test_errors++;
        end
        if (i_instr_addr !== `RV_RESET_ADDR)
            mismatch("o_instr_addr", {16'h0, i_instr_addr}, {16'h0, `RV_RESET_ADDR});
        model_pc = {16'h0, `RV_RESET_ADDR};
        exp_rd.delete();
        exp_data.delete();
        while (next_write(nrd, ndata))
        begin
            exp_rd.push_back(nrd);
            exp_data.push_back(ndata);
        end
    endtask

    task automatic check_retire();
        retires++;
        if (!seen_ack)
        begin
            $display("ERROR at %0t: retire before any instruction was acked", $time);
            errors++;
            test_errors++;
        end
        if (exp_rd.size() == 0)
        begin
            $display("ERROR at %0t: unexpected retire of x%0d", $time, i_retire_rd);
            errors++;
            test_errors++;
        end
        else
        begin
            nrd = exp_rd.pop_front();
            ndata = exp_data.pop_front();
            if (i_retire_rd !== nrd)
                mismatch("o_retire_rd", {27'b0, i_retire_rd}, {27'b0, nrd});
            if (i_retire_data !== ndata)
                mismatch("o_retire_data", i_retire_data, ndata);
        end
    endtask

    task automatic report_test();
        if ((test_errors == 0) && (exp_rd.size() == 0))
            $display("test %0d passed, %0d retires", i_test_num, retires);
        else
        begin
            $display("test %0d failed, %0d errors, %0d writes missing", i_test_num,
                     test_errors, exp_rd.size());
            tests_failed++;
        end
        test_errors = 0;
        retires = 0;
    endtask

    // Sampled at the rising edge, before the DUT registers update.
    always @(posedge i_clk)
    begin
        if (i_reset)
            seen_ack = 1'b0;
        else
        begin
            if (prev_reset)
                start_test();
            if (i_retire_valid)
                check_retire();
            if (i_instr_req && i_instr_ack)
                seen_ack = 1'b1;
        end
        if (i_test_end)
            report_test();
        prev_reset = i_reset;
        o_pending = exp_rd.size();
    end

endmodule

// ==== tests/rv_tb.sv ====
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_tb;

    localparam int NUM_TESTS = 6;
    localparam int EXECUTED = 72;   // Instructions run by all six programs.
    localparam int CYCLE_LIMIT = 8 * EXECUTED + 50 * NUM_TESTS;

    logic                       i_clk;
    logic                       i_reset;
    logic                       o_instr_req;
    logic [`RV_IADDR_W-1:0]     o_instr_addr;
    logic                       i_instr_ack;
    logic [`RV_XLEN-1:0]        i_instr_data;
    logic                       o_retire_valid;
    logic [`RV_REG_AW-1:0]      o_retire_rd;
    logic [`RV_XLEN-1:0]        o_retire_data;

    logic [31:0]    mem [0:255];
    logic           test_end;
    logic           random_acks;
    int             test_num;
    int             pending;
    int             errors;
    int             tests_failed;
    int             seed;
    int             ack_wait;
    int             cycles;
    int             load_idx;

    rv_top DUT
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    rv_checker u_checker
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_req    (o_instr_req),
        .i_instr_addr   (o_instr_addr),
        .i_instr_ack    (i_instr_ack),
        .i_retire_valid (o_retire_valid),
        .i_retire_rd    (o_retire_rd),
        .i_retire_data  (o_retire_data),
        .i_mem          (mem),
        .i_test_end     (test_end),
        .i_test_num     (test_num),
        .o_pending      (pending),
        .o_errors       (errors),
        .o_tests_failed (tests_failed)
    );

    always #10 i_clk = ~i_clk;

    // Instruction memory acks every cycle, or after a random wait of 0 to 3 cycles.
    always @(negedge i_clk)
    begin
        if (ack_wait == 0)
        begin
            i_instr_ack = 1'b1;
            i_instr_data = mem[o_instr_addr[9:2]];
            ack_wait = random_acks ? {$random(seed)} % 4 : 0;
        end
        else
        begin
            i_instr_ack = 1'b0;
            ack_wait = ack_wait - 1;
        end
    end

    always @(posedge i_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic emit(input logic [31:0] word);
        mem[load_idx] = word;
        load_idx++;
    endtask

    task automatic emit_i(input int f3, input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP_IMM});
    endtask

    task automatic emit_r(input int f7, input int f3, input int rd, input int rs1,
                          input int rs2);
        emit({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP});
    endtask

    task automatic emit_b(input int f3, input int rs1, input int rs2, input int off);
        emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
              `RV_OPC_BRANCH});
    endtask

    task automatic emit_lui(input int rd, input int upper);
        emit({upper[19:0], rd[4:0], `RV_OPC_LUI});
    endtask

    task automatic emit_jal(input int rd, input int off);
        emit({off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OPC_JAL});
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 256; i++)
            mem[i] = {17'b0, i[7:0], 7'b0};     // Opcode zero is not decoded.
        load_idx = 0;
        case (t)
            1:
            begin
                emit_i(0, 1, 0, 5);
                emit_i(0, 2, 1, 3);
            end
            2:
            begin
                emit_i(0, 1, 0, -7);
                emit_i(2, 2, 1, 1);
                emit_i(3, 3, 1, 5);
                emit_i(4, 5, 1, 'h0f0);
                emit_i(6, 6, 1, 'h300);
                emit_i(7, 7, 1, 'h07f);
                emit_i(1, 8, 1, 4);
                emit_i(5, 9, 1, 3);
                emit_i(5, 10, 1, 'h402);
                emit_lui(11, 'habcde);
                emit_i(0, 12, 11, -1);
                emit_i(3, 13, 0, 1);
            end
            3:
            begin
                emit_i(0, 1, 0, -3);
                emit_i(0, 2, 0, 7);
                emit_lui(3, 'h80000);
                emit_r(0, 0, 4, 1, 2);
                emit_r('h20, 0, 5, 0, 2);
                emit_r(0, 1, 6, 2, 2);
                emit_r(0, 2, 7, 1, 2);
                emit_r(0, 2, 8, 2, 1);
                emit_r(0, 3, 9, 1, 2);
                emit_r(0, 4, 10, 1, 2);
                emit_r(0, 5, 11, 3, 2);
                emit_r('h20, 5, 12, 3, 2);
                emit_r(0, 6, 13, 1, 2);
                emit_r(0, 7, 14, 1, 2);
            end
            4:
            begin
                emit_i(0, 1, 0, 1);
                emit_i(0, 2, 1, 2);
                emit_i(0, 3, 1, 4);
                emit_r(0, 0, 4, 2, 3);
                emit_r(0, 0, 5, 4, 4);
                emit_r('h20, 0, 6, 5, 1);
                emit_r(0, 0, 7, 6, 5);
            end
            5:
            begin
                emit_i(0, 1, 0, 5);
                emit_i(0, 2, 0, -5);
                emit_b(0, 1, 1, 12);
                emit_i(0, 3, 0, 99);
                emit_i(0, 4, 0, 98);
                emit_b(1, 1, 1, 8);
                emit_i(0, 5, 0, 1);
                emit_b(4, 2, 1, 8);
                emit_i(0, 6, 0, 97);
                emit_b(5, 2, 1, 8);
                emit_i(0, 7, 0, 2);
                emit_b(6, 2, 1, 8);
                emit_i(0, 8, 0, 3);
                emit_b(7, 2, 1, 8);
                emit_i(0, 9, 0, 96);
                emit_jal(10, 8);
                emit_i(0, 11, 0, 95);
                emit_i(0, 12, 10, 1);
            end
            default:
            begin
                emit_i(0, 1, 0, 0);
                emit_i(0, 2, 0, 5);
                emit_i(0, 1, 1, 3);         // Loop body runs five times.
                emit_i(0, 2, 2, -1);
                emit_b(1, 2, 0, -8);
                emit_r(0, 0, 3, 1, 1);
            end
        endcase
        emit_jal(0, 0);
    endtask

    task automatic run_test(input int t);
        i_reset = 1'b1;
        random_acks = (t == NUM_TESTS);
        load_program(t);
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        test_num = t;
        @(negedge i_clk);
        while (pending != 0)
            @(negedge i_clk);
        repeat (10) @(negedge i_clk);   // Late retires would show up here.
        test_end = 1'b1;
        @(negedge i_clk);
        test_end = 1'b0;
    endtask

    initial
    begin
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_instr_ack = 1'b0;
        i_instr_data = '0;
        test_end = 1'b0;
        random_acks = 1'b0;
        test_num = 0;
        seed = 32'h6c99cdad;
        ack_wait = 0;
        cycles = 0;
        load_idx = 0;
        @(negedge i_clk);
        for (int t = 1; t <= NUM_TESTS; t++)
            run_test(t);
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if ((tests_failed == 0) && (errors == 0))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_dec_exe_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regs.sv
hw/rv_execute.sv
hw/rv_top.sv
tests/rv_assertions.sv
tests/rv_checker.sv
tests/rv_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FILELIST   = build.f
TOP        = rv_tb
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
PASS_TEXT  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
